// File: compile.f
rtl/requant_pkg.sv
rtl/credit_gate.sv
rtl/bias_add.sv
rtl/scale_table.sv
rtl/mult_array.sv
rtl/e_scale.sv
rtl/requant_top.sv
tb/requant_props.sv
tb/requant_tb.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module requant_tb \
    -f compile.f -o requant_sim \
    && ./obj_dir/requant_sim +verilator+error+limit+1000 | tee /dev/stderr \
    | grep -q "test passed" \
    && echo "simulation ok" \
    || { echo "simulation reported a failure"; exit 1; }

// File: tb/requant_tb.sv
`timescale 1ns/100ps

module requant_tb;

    import requant_pkg::*;

    localparam int LANES     = lanes_default;
    localparam int TAB_DEPTH = tab_depth_default;
    localparam int CREDITS   = credit_max_default;
    localparam int AW        = $clog2(TAB_DEPTH);
    // bound on every wait loop, in cycles
    localparam int WAIT_MAX  = 200;
    // rows per burst
    localparam int ROWS      = 32;

    logic                     clk;
    logic                     e_tail_reset;
    logic                     mode;
    logic                     in_valid;
    logic [2*LANES*acc_w-1:0] in_row;
    logic [2*pix88_w-1:0]     in_bias;
    logic [AW-1:0]            in_entry;
    logic                     have_credit;
    logic                     out_valid;
    logic [2*LANES*q_w-1:0]   out_row;
    logic                     credit_return;
    logic                     cfg_we;
    logic [AW-1:0]            cfg_addr;
    logic [2*tail_w-1:0]      cfg_tail;
    logic [2*rank_w-1:0]      cfg_rank;

    int          timeout_count = 0;
    int          rows_sent     = 0;
    int          rows_seen     = 0;
    // credits still owed by the returner
    int          pending       = 0;
    logic [31:0] rng_state     = 32'h26f2;

    requant_top #(
        .LANES     (LANES),
        .TAB_DEPTH (TAB_DEPTH),
        .CREDITS   (CREDITS)
    ) i_dut (
        .clk           (clk),
        .e_tail_reset  (e_tail_reset),
        .mode          (mode),
        .in_valid      (in_valid),
        .in_row        (in_row),
        .in_bias       (in_bias),
        .in_entry      (in_entry),
        .have_credit   (have_credit),
        .out_valid     (out_valid),
        .out_row       (out_row),
        .credit_return (credit_return),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_tail      (cfg_tail),
        .cfg_rank      (cfg_rank)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // random numbers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;

        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    ////////////////////////////////////////////////////////////
    // consumer, frees each row after 0 to 5 cycles
    ////////////////////////////////////////////////////////////

    initial begin : credit_returner
        int          due_q[$];
        int          cycle;
        int          due;
        logic [31:0] ret_state;

        cycle         = 0;
        due           = 0;
        // own stream so the source draws stay fixed
        ret_state     = xorshift32(32'h26f2);
        credit_return = 1'b0;
        forever begin
            @(posedge clk);
            cycle++;
            if (out_valid) begin
                rows_seen++;
                ret_state = xorshift32(ret_state);
                due       = cycle + int'(ret_state % 6);
                // slots are freed in order
                if (due_q.size() > 0 && due < due_q[$]) begin
                    due = due_q[$];
                end
                due_q.push_back(due);
            end
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                void'(due_q.pop_front());
                credit_return <= 1'b1;
            end else begin
                credit_return <= 1'b0;
            end
            pending = due_q.size();
        end
    end

    ////////////////////////////////////////////////////////////
    // source tasks
    ////////////////////////////////////////////////////////////

    task automatic load_table();
        logic [31:0]       r;
        logic [rank_w-1:0] rk [2];

        for (int e = 0; e < TAB_DEPTH; e++) begin
            @(posedge clk);
            for (int g = 0; g < 2; g++) begin
                r = rand32();
                case (e % 4)
                    // rank 0 clips nearly every lane
                    0: rk[g] = '0;
                    // shifts the whole product out
                    1: rk[g] = rank_w'(48 + r % 16);
                    default: rk[g] = rank_w'(12 + r % 20);
                endcase
            end
            r = rand32();
            cfg_we   <= 1'b1;
            cfg_addr <= AW'(e);
            cfg_tail <= r[2*tail_w-1:0];
            cfg_rank <= {rk[1], rk[0]};
        end
        @(posedge clk);
        cfg_we <= 1'b0;
    endtask

    task automatic send_burst(input int n);
        logic [31:0]              r;
        logic [2*LANES*acc_w-1:0] row;
        logic [2*pix88_w-1:0]     bias;
        int                       waited;

        for (int k = 0; k < n; k++) begin
            // no row in the last cycle, so the credit count can only grow here
            waited = 0;
            @(posedge clk);
            while (!have_credit && waited < WAIT_MAX) begin
                @(posedge clk);
                waited++;
            end
            if (!have_credit) begin
                timeout_count++;
                $display("timeout at %0t, no credit came back for row %0d", $time, k);
            end else begin
                for (int i = 0; i < 2*LANES; i++) begin
                    r = rand32();
                    row[i*acc_w +: acc_w] = r[acc_w-1:0];
                end
                r = rand32();
                bias[0 +: pix88_w] = r[pix88_w-1:0];
                r = rand32();
                bias[pix88_w +: pix88_w] = r[pix88_w-1:0];
                r = rand32();
                in_valid <= 1'b1;
                in_row   <= row;
                in_bias  <= bias;
                in_entry <= AW'(r % TAB_DEPTH);
                @(posedge clk);
                in_valid <= 1'b0;
                rows_sent++;
                r = rand32();
                repeat (int'(r % 3)) @(posedge clk);
            end
        end
    endtask

    // wait until every row is out and every credit is back
    task automatic drain_pipeline();
        int waited;

        waited = 0;
        @(posedge clk);
        while ((rows_seen != rows_sent || pending != 0) && waited < WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (rows_seen != rows_sent || pending != 0) begin
            timeout_count++;
            $display("timeout at %0t, pipeline did not drain", $time);
        end
        repeat (2) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int mismatch;
        int fails;

        e_tail_reset = 1'b1;
        mode         = mode_88;
        in_valid     = 1'b0;
        in_row       = '0;
        in_bias      = '0;
        in_entry     = '0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_tail     = '0;
        cfg_rank     = '0;
        repeat (10) @(posedge clk);
        e_tail_reset <= 1'b0;

        load_table();
        send_burst(ROWS);
        drain_pipeline();
        // mode only changes with the pipeline empty
        mode <= mode_18;
        send_burst(ROWS);
        drain_pipeline();

        mismatch = (rows_sent != rows_seen || rows_sent != 2*ROWS) ? 1 : 0;
        if (mismatch != 0) begin
            $display("rows sent %0d but rows received %0d", rows_sent, rows_seen);
        end
        fails = i_dut.u_props.fail_count;
        $display("timeouts %0d, row count mismatches %0d, assertion failures %0d",
                 timeout_count, mismatch, fails);
        if (timeout_count == 0 && mismatch == 0 && fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tb/requant_props.sv
`timescale 1ns/100ps

module requant_props #(
    parameter int LANES     = requant_pkg::lanes_default,
    parameter int TAB_DEPTH = requant_pkg::tab_depth_default,
    parameter int CREDITS   = requant_pkg::credit_max_default
) (
    input logic                                    clk,
    input logic                                    e_tail_reset,
    input logic                                    mode,
    input logic                                    in_valid,
    input logic [2*LANES*requant_pkg::acc_w-1:0]   in_row,
    input logic [2*requant_pkg::pix88_w-1:0]       in_bias,
    input logic [$clog2(TAB_DEPTH)-1:0]            in_entry,
    input logic                                    have_credit,
    input logic                                    out_valid,
    input logic [2*LANES*requant_pkg::q_w-1:0]     out_row,
    input logic                                    credit_return,
    input logic                                    cfg_we,
    input logic [$clog2(TAB_DEPTH)-1:0]            cfg_addr,
    input logic [2*requant_pkg::tail_w-1:0]        cfg_tail,
    input logic [2*requant_pkg::rank_w-1:0]        cfg_rank
);

    import requant_pkg::*;

    localparam int AW = $clog2(TAB_DEPTH);

    // read by the testbench for its verdict
    int fail_count = 0;
    // rows accepted and not yet given back by the consumer
    int outstanding;
    // reset as seen on the previous edge
    logic rst_d = 1'b0;
    logic accept;

    // shadow of accepted inputs, index 2 is the row leaving now
    logic [2:0]               acc_d;
    logic [2:0]               mode_d;
    logic [2*LANES*acc_w-1:0] row_d   [3];
    logic [2*pix88_w-1:0]     bias_d  [3];
    logic [AW-1:0]            entry_d [3];

    // copy of the scale table, built from cfg writes
    logic [2*tail_w-1:0] tab_tail [TAB_DEPTH];
    logic [2*rank_w-1:0] tab_rank [TAB_DEPTH];

    logic [2*LANES*q_w-1:0] exp_row;
    logic [2*LANES-1:0]     exp_sat;
    logic [2*LANES-1:0]     sat_hit;

    // a row counts as accepted whenever the source raises in_valid
    assign accept = in_valid;

    ////////////////////////////////////////////////////////////
    // shadow registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        rst_d <= e_tail_reset;
        if (e_tail_reset) begin
            acc_d       <= '0;
            outstanding <= 0;
            for (int e = 0; e < TAB_DEPTH; e++) begin
                tab_tail[e] <= '0;
                tab_rank[e] <= '0;
            end
        end else begin
            acc_d       <= {acc_d[1:0], accept};
            mode_d      <= {mode_d[1:0], mode};
            row_d[0]    <= in_row;
            row_d[1]    <= row_d[0];
            row_d[2]    <= row_d[1];
            bias_d[0]   <= in_bias;
            bias_d[1]   <= bias_d[0];
            bias_d[2]   <= bias_d[1];
            entry_d[0]  <= in_entry;
            entry_d[1]  <= entry_d[0];
            entry_d[2]  <= entry_d[1];
            outstanding <= outstanding + int'(accept) - int'(credit_return);
            if (cfg_we) begin
                tab_tail[cfg_addr] <= cfg_tail;
                tab_rank[cfg_addr] <= cfg_rank;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // msb flags a clipped lane
    function automatic logic [q_w:0] quant_lane(input logic [pix88_w-1:0] sum,
                                                input logic [tail_w-1:0]  tail,
                                                input logic [rank_w-1:0]  rank);
        logic [mult_p_w-1:0] prod;
        logic [mult_p_w-1:0] s;

        prod = mult_p_w'(sum) * mult_p_w'(tail);
        s    = prod >> rank;
        if (s > 255) begin
            return {1'b1, 8'hff};
        end
        return {1'b0, s[q_w-1:0]};
    endfunction

    always_comb begin
        logic [pix18_w-1:0] s16;
        logic [pix88_w-1:0] sum;
        logic [q_w:0]       ql;
        int                 g;

        exp_row = '0;
        exp_sat = '0;
        sat_hit = '0;
        s16     = '0;
        sum     = '0;
        ql      = '0;
        g       = 0;
        for (int i = 0; i < 2*LANES; i++) begin
            g  = (i < LANES) ? 0 : 1;
            ql = '0;
            if (mode_d[2] == mode_88) begin
                // one 24 bit channel, upper lanes stay zero
                if (i < LANES) begin
                    sum = row_d[2][i*pix88_w +: pix88_w] + bias_d[2][0 +: pix88_w];
                    ql  = quant_lane(sum, tab_tail[entry_d[2]][0 +: tail_w],
                                     tab_rank[entry_d[2]][0 +: rank_w]);
                end
            end else begin
                // two 16 bit channels, low bits of the group bias
                s16 = row_d[2][i*pix18_w +: pix18_w] + bias_d[2][g*pix88_w +: pix18_w];
                ql  = quant_lane(pix88_w'(s16), tab_tail[entry_d[2]][g*tail_w +: tail_w],
                                 tab_rank[entry_d[2]][g*rank_w +: rank_w]);
            end
            exp_row[i*q_w +: q_w] = ql[q_w-1:0];
            exp_sat[i]            = ql[q_w];
            sat_hit[i]            = (out_row[i*q_w +: q_w] == 8'hff);
        end
    end

    ////////////////////////////////////////////////////////////
    // assertions
    ////////////////////////////////////////////////////////////

    // three cycles from accept to out_valid, never otherwise
    a_latency: assert property (@(posedge clk) disable iff (e_tail_reset)
        out_valid == acc_d[2])
        else begin
            fail_count = fail_count + 1;
            $error("FAILED %0t out_valid got %b expected %b", $time,
                   $sampled(out_valid), $sampled(acc_d[2]));
        end

    a_mode88_row: assert property (@(posedge clk) disable iff (e_tail_reset)
        out_valid && mode_d[2] == mode_88 |-> out_row == exp_row)
        else begin
            fail_count = fail_count + 1;
            $error("FAILED %0t out_row got %h expected %h", $time,
                   $sampled(out_row), $sampled(exp_row));
        end

    // each half scales with its own tail and rank
    a_mode18_row: assert property (@(posedge clk) disable iff (e_tail_reset)
        out_valid && mode_d[2] == mode_18 |-> out_row == exp_row)
        else begin
            fail_count = fail_count + 1;
            $error("FAILED %0t out_row got %h expected %h", $time,
                   $sampled(out_row), $sampled(exp_row));
        end

    a_saturate: assert property (@(posedge clk) disable iff (e_tail_reset)
        out_valid |-> (sat_hit & exp_sat) == exp_sat)
        else begin
            fail_count = fail_count + 1;
            $error("FAILED %0t saturated lanes got %b expected %b", $time,
                   $sampled(sat_hit & exp_sat), $sampled(exp_sat));
        end

    a_credit_bound: assert property (@(posedge clk) disable iff (e_tail_reset)
        outstanding <= CREDITS)
        else begin
            fail_count = fail_count + 1;
            $error("more rows in flight than the consumer has slots");
        end

    // skip the load cycle right after reset
    a_credit_flag: assert property (@(posedge clk) disable iff (e_tail_reset)
        !rst_d |-> have_credit == (outstanding != CREDITS))
        else begin
            fail_count = fail_count + 1;
            $error("FAILED %0t have_credit got %b expected %b", $time,
                   $sampled(have_credit), $sampled(outstanding != CREDITS));
        end

    a_source_rule: assert property (@(posedge clk) disable iff (e_tail_reset)
        !(in_valid && !have_credit))
        else begin
            fail_count = fail_count + 1;
            $error("in_valid driven while have_credit is low");
        end

    a_reset_quiet: assert property (@(posedge clk)
        e_tail_reset && rst_d |-> !out_valid && !have_credit)
        else begin
            fail_count = fail_count + 1;
            $error("out_valid or have_credit high during reset");
        end

    a_reset_row: assert property (@(posedge clk)
        !e_tail_reset && rst_d |-> out_row == '0)
        else begin
            fail_count = fail_count + 1;
            $error("FAILED %0t out_row got %h expected 0", $time, $sampled(out_row));
        end

endmodule

bind requant_top requant_props #(
    .LANES     (LANES),
    .TAB_DEPTH (TAB_DEPTH),
    .CREDITS   (CREDITS)
) u_props (
    .clk           (clk),
    .e_tail_reset  (e_tail_reset),
    .mode          (mode),
    .in_valid      (in_valid),
    .in_row        (in_row),
    .in_bias       (in_bias),
    .in_entry      (in_entry),
    .have_credit   (have_credit),
    .out_valid     (out_valid),
    .out_row       (out_row),
    .credit_return (credit_return),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_tail      (cfg_tail),
    .cfg_rank      (cfg_rank)
);

// File: rtl/requant_top.sv
`timescale 1ns/100ps

module requant_top #(
    parameter int LANES     = requant_pkg::lanes_default,
    parameter int TAB_DEPTH = requant_pkg::tab_depth_default,
    parameter int CREDITS   = requant_pkg::credit_max_default
) (
    input  logic                                    clk,
    input  logic                                    e_tail_reset,
    input  logic                                    mode,
    // source side
    input  logic                                    in_valid,
    input  logic [2*LANES*requant_pkg::acc_w-1:0]   in_row,
    input  logic [2*requant_pkg::pix88_w-1:0]       in_bias,
    input  logic [$clog2(TAB_DEPTH)-1:0]            in_entry,
    output logic                                    have_credit,
    // consumer side
    output logic                                    out_valid,
    output logic [2*LANES*requant_pkg::q_w-1:0]     out_row,
    input  logic                                    credit_return,
    // scale table configuration
    input  logic                                    cfg_we,
    input  logic [$clog2(TAB_DEPTH)-1:0]            cfg_addr,
    input  logic [2*requant_pkg::tail_w-1:0]        cfg_tail,
    input  logic [2*requant_pkg::rank_w-1:0]        cfg_rank
);

    import requant_pkg::*;

    logic                        accept;
    logic                        biased_valid;
    logic [2*LANES*pix88_w-1:0]  biased_row;
    logic [2*tail_w-1:0]         tail_set;
    logic [2*rank_w-1:0]         rank_set;
    logic [2*LANES*mult_a_w-1:0] mult_a;
    logic [2*LANES*mult_b_w-1:0] mult_b;
    logic [2*LANES*mult_p_w-1:0] mult_p;

    ////////////////////////////////////////////////////////////
    // input side, credits, bias and table lookup
    ////////////////////////////////////////////////////////////

    credit_gate #(.CREDITS(CREDITS)) u_credit_gate (
        .clk           (clk),
        .e_tail_reset  (e_tail_reset),
        .in_valid      (in_valid),
        .credit_return (credit_return),
        .have_credit   (have_credit),
        .accept        (accept)
    );

    bias_add #(.LANES(LANES)) u_bias_add (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .accept       (accept),
        .mode         (mode),
        .in_row       (in_row),
        .in_bias      (in_bias),
        .biased_valid (biased_valid),
        .biased_row   (biased_row)
    );

    // entry is looked up every cycle, used on the accept cycle
    scale_table #(.LANES(LANES), .TAB_DEPTH(TAB_DEPTH)) u_scale_table (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_tail     (cfg_tail),
        .cfg_rank     (cfg_rank),
        .rd_addr      (in_entry),
        .tail_set     (tail_set),
        .rank_set     (rank_set)
    );

    ////////////////////////////////////////////////////////////
    // scale stage around the multiplier column
    ////////////////////////////////////////////////////////////

    e_scale #(.LANES(LANES)) u_e_scale (
        .clk          (clk),
        .e_tail_reset (e_tail_reset),
        .mode         (mode),
        .biased_valid (biased_valid),
        .biased_row   (biased_row),
        .tail_set     (tail_set),
        .rank_set     (rank_set),
        .mult_a       (mult_a),
        .mult_b       (mult_b),
        .mult_p       (mult_p),
        .out_valid    (out_valid),
        .out_row      (out_row)
    );

    mult_array #(.LANES(LANES)) u_mult_array (
        .clk    (clk),
        .mult_a (mult_a),
        .mult_b (mult_b),
        .mult_p (mult_p)
    );

endmodule

// File: rtl/e_scale.sv
`timescale 1ns/100ps

module e_scale #(
    parameter int LANES = requant_pkg::lanes_default
) (
    input  logic                                      clk,
    input  logic                                      e_tail_reset,
    input  logic                                      mode,
    input  logic                                      biased_valid,
    input  logic [2*LANES*requant_pkg::pix88_w-1:0]   biased_row,
    input  logic [2*requant_pkg::tail_w-1:0]          tail_set,
    input  logic [2*requant_pkg::rank_w-1:0]          rank_set,
    output logic [2*LANES*requant_pkg::mult_a_w-1:0]  mult_a,
    output logic [2*LANES*requant_pkg::mult_b_w-1:0]  mult_b,
    input  logic [2*LANES*requant_pkg::mult_p_w-1:0]  mult_p,
    output logic                                      out_valid,
    output logic [2*LANES*requant_pkg::q_w-1:0]       out_row
);

    import requant_pkg::*;

    // rank and valid delayed to line up with mult_p
    logic [2*rank_w-1:0]    rank_d;
    logic                   valid_d;
    // saturated row before the output register
    logic [2*LANES*q_w-1:0] q_row;

    ////////////////////////////////////////////////////////////
    // stage 0, multiplier operands
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic [tail_w-1:0] tail;

        tail = '0;
        for (int i = 0; i < 2*LANES; i++) begin
            // pixels go straight to A, upper lanes are zero in mode 0
            mult_a[i*mult_a_w +: mult_a_w] = mult_a_w'(biased_row[i*pix88_w +: pix88_w]);
            // group 0 tail serves both modes
            if (i < LANES) begin
                tail = tail_set[0 +: tail_w];
            end else if (mode == mode_18) begin
                tail = tail_set[tail_w +: tail_w];
            end else begin
                tail = '0;
            end
            mult_b[i*mult_b_w +: mult_b_w] = mult_b_w'(tail);
        end
    end

    // ranks wait one cycle for the products
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            rank_d  <= '0;
            valid_d <= 1'b0;
        end else begin
            rank_d  <= rank_set;
            valid_d <= biased_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 1, shift by rank and saturate
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic [mult_p_w-1:0] prod;
        logic [rank_w-1:0]   rank;
        logic [mult_p_w-1:0] shifted;

        prod    = '0;
        rank    = '0;
        shifted = '0;
        for (int i = 0; i < 2*LANES; i++) begin
            prod = mult_p[i*mult_p_w +: mult_p_w];
            // each group shifts by its own rank
            rank = (i < LANES) ? rank_d[0 +: rank_w] : rank_d[rank_w +: rank_w];
            shifted = prod >> rank;
            if (mode == mode_88 && i >= LANES) begin
                q_row[i*q_w +: q_w] = '0;
            end else if (|shifted[mult_p_w-1:q_w]) begin
                // anything 256 or above clips to full scale
                q_row[i*q_w +: q_w] = '1;
            end else begin
                q_row[i*q_w +: q_w] = shifted[q_w-1:0];
            end
        end
    end

    // quantizer register, held between rows
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            out_valid <= 1'b0;
            out_row   <= '0;
        end else begin
            out_valid <= valid_d;
            if (valid_d) begin
                out_row <= q_row;
            end
        end
    end

endmodule

// File: rtl/mult_array.sv
`timescale 1ns/100ps

module mult_array #(
    parameter int LANES = requant_pkg::lanes_default
) (
    input  logic                                      clk,
    input  logic [2*LANES*requant_pkg::mult_a_w-1:0]  mult_a,
    input  logic [2*LANES*requant_pkg::mult_b_w-1:0]  mult_b,
    output logic [2*LANES*requant_pkg::mult_p_w-1:0]  mult_p
);

    import requant_pkg::*;

    ////////////////////////////////////////////////////////////
    // registered lane multipliers
    ////////////////////////////////////////////////////////////

    // one unsigned multiplier per lane, product registered once
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2*LANES; i++) begin
            // 24 x 16 fits the 40 bit product without loss
            mult_p[i*mult_p_w +: mult_p_w] <=
                mult_a[i*mult_a_w +: mult_a_w] * mult_b[i*mult_b_w +: mult_b_w];
        end
    end

endmodule

// File: rtl/scale_table.sv
`timescale 1ns/100ps

module scale_table #(
    parameter int LANES     = requant_pkg::lanes_default,
    parameter int TAB_DEPTH = requant_pkg::tab_depth_default
) (
    input  logic                               clk,
    input  logic                               e_tail_reset,
    input  logic                               cfg_we,
    input  logic [$clog2(TAB_DEPTH)-1:0]       cfg_addr,
    input  logic [2*requant_pkg::tail_w-1:0]   cfg_tail,
    input  logic [2*requant_pkg::rank_w-1:0]   cfg_rank,
    input  logic [$clog2(TAB_DEPTH)-1:0]       rd_addr,
    output logic [2*requant_pkg::tail_w-1:0]   tail_set,
    output logic [2*requant_pkg::rank_w-1:0]   rank_set
);

    import requant_pkg::*;

    // each entry holds one tail and one rank per channel group
    logic [2*tail_w-1:0] tail_mem [TAB_DEPTH];
    logic [2*rank_w-1:0] rank_mem [TAB_DEPTH];

    // index needs at least one bit, and a row needs lanes to scale
    if (TAB_DEPTH < 2 || LANES < 1) begin : g_bad_geometry
        $error("scale_table needs TAB_DEPTH >= 2 and LANES >= 1");
    end

    ////////////////////////////////////////////////////////////
    // configuration writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            for (int e = 0; e < TAB_DEPTH; e++) begin
                tail_mem[e] <= '0;
                rank_mem[e] <= '0;
            end
        end else if (cfg_we) begin
            // writes only happen with the pipeline empty
            tail_mem[cfg_addr] <= cfg_tail;
            rank_mem[cfg_addr] <= cfg_rank;
        end
    end

    ////////////////////////////////////////////////////////////
    // registered read
    ////////////////////////////////////////////////////////////

    // read on the accept cycle lands next to biased_row
    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            tail_set <= '0;
            rank_set <= '0;
        end else begin
            tail_set <= tail_mem[rd_addr];
            rank_set <= rank_mem[rd_addr];
        end
    end

endmodule

// File: rtl/bias_add.sv
`timescale 1ns/100ps

module bias_add #(
    parameter int LANES = requant_pkg::lanes_default
) (
    input  logic                                      clk,
    input  logic                                      e_tail_reset,
    input  logic                                      accept,
    input  logic                                      mode,
    input  logic [2*LANES*requant_pkg::acc_w-1:0]     in_row,
    input  logic [2*requant_pkg::pix88_w-1:0]         in_bias,
    output logic                                      biased_valid,
    output logic [2*LANES*requant_pkg::pix88_w-1:0]   biased_row
);

    import requant_pkg::*;

    // next biased row, every lane already in the 24 bit format
    logic [2*LANES*pix88_w-1:0] sum_row;

    ////////////////////////////////////////////////////////////
    // per lane bias add
    ////////////////////////////////////////////////////////////

    always_comb begin
        logic [pix18_w-1:0] sum18;
        int                 grp;

        sum_row = '0;
        sum18   = '0;
        grp     = 0;
        for (int i = 0; i < 2*LANES; i++) begin
            // group 0 is the low half of the lanes
            grp = (i < LANES) ? 0 : 1;
            if (mode == mode_88) begin
                // one channel, wide pixels, upper half stays zero
                if (i < LANES) begin
                    sum_row[i*pix88_w +: pix88_w] =
                        in_row[i*pix88_w +: pix88_w] + in_bias[0 +: pix88_w];
                end
            end else begin
                // two channels, each uses the low bits of its own bias
                sum18 = in_row[i*pix18_w +: pix18_w] + in_bias[grp*pix88_w +: pix18_w];
                sum_row[i*pix88_w +: pix88_w] = pix88_w'(sum18);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            biased_valid <= 1'b0;
            biased_row   <= '0;
        end else begin
            biased_valid <= accept;
            // hold the last row between accepts
            if (accept) begin
                biased_row <= sum_row;
            end
        end
    end

endmodule

// File: rtl/credit_gate.sv
`timescale 1ns/100ps

module credit_gate #(
    parameter int CREDITS = requant_pkg::credit_max_default
) (
    input  logic clk,
    input  logic e_tail_reset,
    input  logic in_valid,
    input  logic credit_return,
    output logic have_credit,
    output logic accept
);

    // counter must be able to hold the full credit count
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    // set once the counter has been loaded after reset
    logic             loaded;

    // a row is only taken while a slot is free downstream
    assign have_credit = (credit_cnt != '0);
    assign accept      = in_valid & have_credit;

    ////////////////////////////////////////////////////////////
    // credit counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (e_tail_reset) begin
            loaded     <= 1'b0;
            credit_cnt <= '0;
        end else if (!loaded) begin
            // first cycle out of reset, consumer owns all slots free
            loaded     <= 1'b1;
            credit_cnt <= CNT_W'(CREDITS);
        end else if (accept && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!accept && credit_return) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
        // accept and return together leave the count as is
    end

endmodule

// File: rtl/requant_pkg.sv
package requant_pkg;

    ////////////////////////////////////////////////////////////
    // lane geometry
    ////////////////////////////////////////////////////////////

    // lanes per channel group, the row carries twice this many
    localparam int lanes_default = 4;

    // raw accumulator lane as seen on in_row in mode 1
    localparam int acc_w = 16;

    // 8x8 pixels are wider, LANES of them packed from bit 0
    localparam int pix88_w = 24;
    localparam int pix18_w = 16;

    ////////////////////////////////////////////////////////////
    // multiplier column
    ////////////////////////////////////////////////////////////

    localparam int mult_a_w = 24;
    localparam int mult_b_w = 16;
    // full product of a 24 x 16 unsigned multiply
    localparam int mult_p_w = 40;

    ////////////////////////////////////////////////////////////
    // scale parameters and output
    ////////////////////////////////////////////////////////////

    localparam int tail_w = 16;
    localparam int rank_w = 8;
    // quantized pixel, saturates at 255
    localparam int q_w = 8;

    localparam int tab_depth_default = 8;

    // mode encoding
    localparam logic mode_88 = 1'b0;
    localparam logic mode_18 = 1'b1;

    // output slots owned by the consumer
    localparam int credit_max_default = 4;

endpackage
